// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    // Cache geometry
    localparam int ADDR_WIDTH  = 16;
    localparam int SETS        = 8;
    localparam int WAYS        = 4;
    localparam int BLOCK_BYTES = 8;

    localparam int OFFSET_BITS = $clog2(BLOCK_BYTES);
    localparam int SET_BITS    = $clog2(SETS);
    localparam int TAG_BITS    = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [SET_BITS-1:0]       set_t;
    typedef logic [$clog2(WAYS)-1:0]   way_t;
    // Bit 0 root, bit 1 left node, bit 2 right node
    typedef logic [2:0]                plru_t;
    typedef logic [4:0]                id_t;
    // Zero means no transaction
    typedef logic [3:0]                mem_tag_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_e;

    typedef enum logic [1:0] {
        BUS_NONE,
        BUS_LOAD,
        BUS_STORE
    } bus_command_e;

    // One cache block, seen at any access width
    typedef union packed {
        logic [BLOCK_BYTES*8-1:0]   dword;
        logic [1:0][31:0]           words;
        logic [3:0][15:0]           halves;
        logic [BLOCK_BYTES-1:0][7:0] bytes;
    } block_data_t;

    function automatic set_t set_of(addr_t addr);
        return addr[OFFSET_BITS +: SET_BITS];
    endfunction

    function automatic tag_t tag_of(addr_t addr);
        return addr[ADDR_WIDTH-1 -: TAG_BITS];
    endfunction

    function automatic addr_t block_base(addr_t addr);
        return {addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

endpackage

// ==== logic/lookup_if.sv ====
`timescale 1ns/100ps

interface lookup_if;

    dcache_pkg::addr_t       addr;
    logic                    valid;
    // Hit already qualified by valid
    logic                    hit;
    dcache_pkg::way_t        way;
    dcache_pkg::block_data_t data;

    modport requester (
        output addr,
        output valid,
        input  hit,
        input  way,
        input  data
    );

    modport responder (
        input  addr,
        input  valid,
        output hit,
        output way,
        output data
    );

endinterface

// ==== logic/tag_lookup.sv ====
`timescale 1ns/100ps

module tag_lookup (
    lookup_if.responder lookup,
    input dcache_pkg::tag_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_tags,
    input logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_valid,
    input dcache_pkg::block_data_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_data
);

    dcache_pkg::set_t lookup_set;
    dcache_pkg::tag_t lookup_tag;

    assign lookup_set = dcache_pkg::set_of(lookup.addr);
    assign lookup_tag = dcache_pkg::tag_of(lookup.addr);

    // At most one way of a set holds a given tag
    always_comb begin
        lookup.hit = 1'b0;
        lookup.way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (block_valid[lookup_set][w] && block_tags[lookup_set][w] == lookup_tag) begin
                lookup.hit = lookup.valid;
                lookup.way = dcache_pkg::way_t'(w);
            end
        end
    end

    // Data of the matched way, way 0 on a miss
    assign lookup.data = block_data[lookup_set][lookup.way];

endmodule

// ==== logic/tree_plru.sv ====
`timescale 1ns/100ps

module tree_plru (
    input  logic                 clock,
    input  logic                 reset,
    input  dcache_pkg::set_t     victim_set,
    input  logic                 load_update,
    input  dcache_pkg::set_t     load_set,
    input  dcache_pkg::way_t     load_way,
    input  logic                 store_update,
    input  dcache_pkg::set_t     store_set,
    input  dcache_pkg::way_t     store_way,
    output dcache_pkg::way_t     victim_way
);

    dcache_pkg::plru_t [dcache_pkg::SETS-1:0] tree;
    dcache_pkg::plru_t victim_bits;
    logic store_apply;

    // Point the root and the touched half's node away from the accessed way
    function automatic dcache_pkg::plru_t touch(dcache_pkg::plru_t bits, dcache_pkg::way_t way);
        dcache_pkg::plru_t next;
        next = bits;
        next[0] = ~way[1];
        if (way[1]) begin
            next[2] = ~way[0];
        end else begin
            next[1] = ~way[0];
        end
        return next;
    endfunction

    assign victim_bits = tree[victim_set];
    assign victim_way  = victim_bits[0] ? {1'b1, victim_bits[2]} : {1'b0, victim_bits[1]};

    // Load side wins when both touch one set
    assign store_apply = store_update && !(load_update && store_set == load_set);

    always_ff @(posedge clock) begin
        if (reset) begin
            tree <= '0;
        end else begin
            if (load_update) begin
                tree[load_set] <= touch(tree[load_set], load_way);
            end
            if (store_apply) begin
                tree[store_set] <= touch(tree[store_set], store_way);
            end
        end
    end

endmodule

// ==== logic/cache_array.sv ====
`timescale 1ns/100ps

module cache_array (
    input  logic                        clock,
    input  logic                        reset,
    lookup_if.requester                 store_lookup,
    input  logic                        store_valid,
    input  dcache_pkg::mem_size_e       store_size,
    input  logic [31:0]                 store_data,
    input  logic                        install,
    input  dcache_pkg::addr_t           install_addr,
    input  dcache_pkg::block_data_t     install_data,
    input  dcache_pkg::way_t            plru_way,
    output dcache_pkg::tag_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_tags,
    output logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_valid,
    output dcache_pkg::block_data_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_data,
    output dcache_pkg::way_t            install_way
);

    dcache_pkg::set_t install_set;
    dcache_pkg::set_t store_set;
    logic [2:0] store_offset;
    logic store_write;

    assign install_set  = dcache_pkg::set_of(install_addr);
    assign store_set    = dcache_pkg::set_of(store_lookup.addr);
    assign store_offset = store_lookup.addr[2:0];
    assign store_write  = store_valid && store_lookup.hit;

    // Lowest invalid way first, tree victim once the set is full
    always_comb begin
        install_way = plru_way;
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!block_valid[install_set][w]) begin
                install_way = dcache_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            block_valid <= '0;
        end else if (install) begin
            block_valid[install_set][install_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (store_write) begin
            case (store_size)
                dcache_pkg::BYTE: begin
                    block_data[store_set][store_lookup.way].bytes[store_offset]
                        <= store_data[7:0];
                end
                dcache_pkg::HALF: begin
                    block_data[store_set][store_lookup.way].halves[store_offset[2:1]]
                        <= store_data[15:0];
                end
                default: begin
                    block_data[store_set][store_lookup.way].words[store_offset[2]]
                        <= store_data;
                end
            endcase
        end
        // Refill lands after the store so an evicting install wins its way
        if (install) begin
            block_tags[install_set][install_way] <= dcache_pkg::tag_of(install_addr);
            block_data[install_set][install_way] <= install_data;
        end
    end

endmodule

// ==== logic/miss_buffer.sv ====
`timescale 1ns/100ps

module miss_buffer #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        allocate,
    input  dcache_pkg::addr_t           load_addr,
    input  dcache_pkg::mem_size_e       load_size,
    input  logic                        load_signed,
    input  dcache_pkg::id_t             load_id,
    input  logic                        response_accepted,
    input  dcache_pkg::mem_tag_t        mem_response,
    input  logic [63:0]                 mem_data,
    input  dcache_pkg::mem_tag_t        mem_data_tag,
    input  logic                        hit_busy,
    output logic                        send_valid,
    output dcache_pkg::addr_t           send_addr,
    output logic                        head_done,
    output dcache_pkg::addr_t           head_addr,
    output dcache_pkg::mem_size_e       head_size,
    output logic                        head_signed,
    output dcache_pkg::id_t             head_id,
    output dcache_pkg::block_data_t     head_data,
    output logic                        full,
    output logic                        empty
);

    localparam int PTR_BITS = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;

    typedef logic [PTR_BITS-1:0] ptr_t;

    logic [BUFFER_DEPTH-1:0] entry_valid;
    logic [BUFFER_DEPTH-1:0] entry_done;
    logic [BUFFER_DEPTH-1:0] capture;
    dcache_pkg::addr_t       entry_addr [BUFFER_DEPTH];
    dcache_pkg::mem_size_e   entry_size [BUFFER_DEPTH];
    logic                    entry_signed [BUFFER_DEPTH];
    dcache_pkg::id_t         entry_id [BUFFER_DEPTH];
    dcache_pkg::mem_tag_t    entry_tag [BUFFER_DEPTH];
    dcache_pkg::block_data_t entry_data [BUFFER_DEPTH];

    ptr_t head_ptr;
    ptr_t send_ptr;
    ptr_t tail_ptr;
    logic retire;

    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Unsent entries hold tag zero and never match
    always_comb begin
        for (int i = 0; i < BUFFER_DEPTH; i++) begin
            capture[i] = entry_valid[i] && !entry_done[i] && mem_data_tag != '0
                && entry_tag[i] == mem_data_tag;
        end
    end

    // Send pointer wraps onto the head once every entry is sent
    assign send_valid  = entry_valid[send_ptr] && !entry_done[send_ptr]
        && entry_tag[send_ptr] == '0;
    assign send_addr   = entry_addr[send_ptr];
    assign head_done   = entry_valid[head_ptr] && entry_done[head_ptr];
    assign head_addr   = entry_addr[head_ptr];
    assign head_size   = entry_size[head_ptr];
    assign head_signed = entry_signed[head_ptr];
    assign head_id     = entry_id[head_ptr];
    assign head_data   = entry_data[head_ptr];
    assign retire      = head_done && !hit_busy;
    assign full        = head_ptr == tail_ptr && entry_valid[head_ptr];
    assign empty       = head_ptr == tail_ptr && !entry_valid[head_ptr];

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            entry_valid <= '0;
            entry_done  <= '0;
            head_ptr    <= '0;
            send_ptr    <= '0;
            tail_ptr    <= '0;
        end else begin
            entry_done <= entry_done | capture;
            if (response_accepted) begin
                send_ptr <= next_ptr(send_ptr);
            end
            if (retire) begin
                entry_valid[head_ptr] <= 1'b0;
                entry_done[head_ptr]  <= 1'b0;
                head_ptr              <= next_ptr(head_ptr);
            end
            if (allocate) begin
                entry_valid[tail_ptr] <= 1'b1;
                entry_done[tail_ptr]  <= 1'b0;
                tail_ptr              <= next_ptr(tail_ptr);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (allocate) begin
            entry_addr[tail_ptr]   <= load_addr;
            entry_size[tail_ptr]   <= load_size;
            entry_signed[tail_ptr] <= load_signed;
            entry_id[tail_ptr]     <= load_id;
            entry_tag[tail_ptr]    <= '0;
        end
        if (response_accepted) begin
            entry_tag[send_ptr] <= mem_response;
        end
        for (int i = 0; i < BUFFER_DEPTH; i++) begin
            if (capture[i]) begin
                entry_data[i].dword <= mem_data;
            end
        end
    end

endmodule

// ==== logic/load_align.sv ====
`timescale 1ns/100ps

module load_align (
    lookup_if.requester             hit,
    input  dcache_pkg::addr_t       load_addr,
    input  dcache_pkg::mem_size_e   load_size,
    input  logic                    load_signed,
    input  dcache_pkg::id_t         load_id,
    input  logic                    head_done,
    input  dcache_pkg::addr_t       head_addr,
    input  dcache_pkg::mem_size_e   head_size,
    input  logic                    head_signed,
    input  dcache_pkg::id_t         head_id,
    input  dcache_pkg::block_data_t head_data,
    output logic                    result_valid,
    output logic [31:0]             result_value,
    output dcache_pkg::id_t         result_id
);

    dcache_pkg::block_data_t sel_data;
    dcache_pkg::addr_t       sel_addr;
    dcache_pkg::mem_size_e   sel_size;
    logic                    sel_signed;
    logic [7:0]              sel_byte;
    logic [15:0]             sel_half;

    // A hit takes the port ahead of the buffer head
    assign sel_data   = hit.hit ? hit.data : head_data;
    assign sel_addr   = hit.hit ? load_addr : head_addr;
    assign sel_size   = hit.hit ? load_size : head_size;
    assign sel_signed = hit.hit ? load_signed : head_signed;

    assign result_valid = hit.hit || head_done;
    assign result_id    = hit.hit ? load_id : head_id;

    assign sel_byte = sel_data.bytes[sel_addr[2:0]];
    assign sel_half = sel_data.halves[sel_addr[2:1]];

    always_comb begin
        case (sel_size)
            dcache_pkg::BYTE: result_value = {{24{sel_signed & sel_byte[7]}}, sel_byte};
            dcache_pkg::HALF: result_value = {{16{sel_signed & sel_half[15]}}, sel_half};
            default:          result_value = sel_data.words[sel_addr[2]];
        endcase
    end

endmodule

// ==== logic/dcache.sv ====
`timescale 1ns/100ps

module dcache #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     load_valid,
    input  dcache_pkg::addr_t        load_addr,
    input  dcache_pkg::mem_size_e    load_size,
    input  logic                     load_signed,
    input  dcache_pkg::id_t          load_id,
    input  logic                     store_valid,
    input  dcache_pkg::addr_t        store_addr,
    input  dcache_pkg::mem_size_e    store_size,
    input  logic [31:0]              store_data,
    input  logic                     mem_response_valid,
    input  dcache_pkg::mem_tag_t     mem_response,
    input  logic [63:0]              mem_data,
    input  dcache_pkg::mem_tag_t     mem_data_tag,
    input  logic                     flush,
    output logic                     result_valid,
    output logic [31:0]              result_value,
    output dcache_pkg::id_t          result_id,
    output logic                     buffer_full,
    output logic                     buffer_empty,
    output dcache_pkg::bus_command_e mem_command,
    output dcache_pkg::addr_t        mem_addr,
    output dcache_pkg::mem_size_e    mem_size,
    output logic [63:0]              mem_store_data
);

    dcache_pkg::tag_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0]        block_tags;
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0]                    block_valid;
    dcache_pkg::block_data_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] block_data;

    logic                    send_valid;
    dcache_pkg::addr_t       send_addr;
    logic                    head_done;
    dcache_pkg::addr_t       head_addr;
    dcache_pkg::mem_size_e   head_size;
    logic                    head_signed;
    dcache_pkg::id_t         head_id;
    dcache_pkg::block_data_t head_data;
    dcache_pkg::way_t        plru_way;
    dcache_pkg::way_t        install_way;
    logic                    response_accepted;
    logic                    install;

    lookup_if load_lookup ();
    lookup_if store_lookup ();
    lookup_if head_lookup ();

    assign load_lookup.addr   = load_addr;
    assign load_lookup.valid  = load_valid;
    assign store_lookup.addr  = store_addr;
    assign store_lookup.valid = store_valid;
    assign head_lookup.addr   = head_addr;
    assign head_lookup.valid  = head_done;

    tag_lookup load_tags (.lookup(load_lookup.responder), .block_tags, .block_valid, .block_data);
    tag_lookup store_tags (.lookup(store_lookup.responder), .block_tags, .block_valid, .block_data);
    tag_lookup head_tags (.lookup(head_lookup.responder), .block_tags, .block_valid, .block_data);

    // Head retires when no hit holds the result port
    // Refill skipped if its block got resident in the meantime
    assign install = head_done && !load_lookup.hit && !head_lookup.hit;

    tree_plru plru (
        .clock        (clock),
        .reset        (reset),
        .victim_set   (dcache_pkg::set_of(head_addr)),
        .load_update  (load_lookup.hit || install),
        .load_set     (dcache_pkg::set_of(load_lookup.hit ? load_addr : head_addr)),
        .load_way     (load_lookup.hit ? load_lookup.way : install_way),
        .store_update (store_lookup.hit),
        .store_set    (dcache_pkg::set_of(store_addr)),
        .store_way    (store_lookup.way),
        .victim_way   (plru_way)
    );

    cache_array array (
        .clock        (clock),
        .reset        (reset),
        .store_lookup (store_lookup.requester),
        .store_valid  (store_valid),
        .store_size   (store_size),
        .store_data   (store_data),
        .install      (install),
        .install_addr (head_addr),
        .install_data (head_data),
        .plru_way     (plru_way),
        .block_tags   (block_tags),
        .block_valid  (block_valid),
        .block_data   (block_data),
        .install_way  (install_way)
    );

    miss_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) buffer (
        .clock             (clock),
        .reset             (reset),
        .flush             (flush),
        .allocate          (load_valid && !load_lookup.hit),
        .load_addr         (load_addr),
        .load_size         (load_size),
        .load_signed       (load_signed),
        .load_id           (load_id),
        .response_accepted (response_accepted),
        .mem_response      (mem_response),
        .mem_data          (mem_data),
        .mem_data_tag      (mem_data_tag),
        .hit_busy          (load_lookup.hit),
        .send_valid        (send_valid),
        .send_addr         (send_addr),
        .head_done         (head_done),
        .head_addr         (head_addr),
        .head_size         (head_size),
        .head_signed       (head_signed),
        .head_id           (head_id),
        .head_data         (head_data),
        .full              (buffer_full),
        .empty             (buffer_empty)
    );

    load_align align (
        .hit          (load_lookup.requester),
        .load_addr    (load_addr),
        .load_size    (load_size),
        .load_signed  (load_signed),
        .load_id      (load_id),
        .head_done    (head_done),
        .head_addr    (head_addr),
        .head_size    (head_size),
        .head_signed  (head_signed),
        .head_id      (head_id),
        .head_data    (head_data),
        .result_valid (result_valid),
        .result_value (result_value),
        .result_id    (result_id)
    );

    // Stores go first, block reads fill idle cycles
    always_comb begin
        mem_command    = dcache_pkg::BUS_NONE;
        mem_addr       = '0;
        mem_size       = dcache_pkg::DOUBLE;
        mem_store_data = '0;
        if (store_valid) begin
            mem_command    = dcache_pkg::BUS_STORE;
            mem_addr       = store_addr;
            mem_size       = store_size;
            mem_store_data = {32'b0, store_data};
        end else if (send_valid) begin
            mem_command = dcache_pkg::BUS_LOAD;
            mem_addr    = dcache_pkg::block_base(send_addr);
        end
    end

    assign response_accepted = mem_response_valid && mem_response != '0
        && mem_command == dcache_pkg::BUS_LOAD;

endmodule

// ==== testbench/dcache_tests.svh ====
`ifndef DCACHE_TESTS_SVH
`define DCACHE_TESTS_SVH

task automatic load_hit(dcache_pkg::addr_t addr, dcache_pkg::mem_size_e size, logic sgn,
                        dcache_pkg::id_t id);
    logic [31:0] expected;
    expected = expected_load(addr, size, sgn);
    @(negedge clock);
    load_valid = 1'b1;
    load_addr = addr;
    load_size = size;
    load_signed = sgn;
    load_id = id;
    @(posedge clock);
    check_value("hit result_valid", result_valid, 1);
    check_value("hit result_value", result_value, expected);
    check_value("hit result_id", result_id, id);
    check_value("hit mem_command", mem_command, dcache_pkg::BUS_NONE);
    @(negedge clock);
    load_valid = 1'b0;
endtask

task automatic load_miss(dcache_pkg::addr_t addr, dcache_pkg::mem_size_e size, logic sgn,
                         dcache_pkg::id_t id, logic check_bus);
    @(negedge clock);
    load_valid = 1'b1;
    load_addr = addr;
    load_size = size;
    load_signed = sgn;
    load_id = id;
    @(negedge clock);
    load_valid = 1'b0;
    if (check_bus) begin
        @(posedge clock);
        check_value("miss mem_command", mem_command, dcache_pkg::BUS_LOAD);
        check_value("miss mem_addr", mem_addr, dcache_pkg::block_base(addr));
        check_value("miss mem_size", mem_size, dcache_pkg::DOUBLE);
    end
endtask

task automatic wait_result(logic [31:0] expected, dcache_pkg::id_t id);
    do @(posedge clock); while (!result_valid);
    check_value("miss result_value", result_value, expected);
    check_value("miss result_id", result_id, id);
endtask

task automatic store_write(dcache_pkg::addr_t addr, dcache_pkg::mem_size_e size,
                           logic [31:0] data);
    @(negedge clock);
    store_valid = 1'b1;
    store_addr = addr;
    store_size = size;
    store_data = data;
    @(posedge clock);
    check_value("store mem_command", mem_command, dcache_pkg::BUS_STORE);
    check_value("store mem_addr", mem_addr, addr);
    check_value("store mem_size", mem_size, size);
    check_value("store mem_store_data", mem_store_data, {32'b0, data});
    @(negedge clock);
    store_valid = 1'b0;
endtask

task automatic reset_outputs();
    @(posedge clock);
    check_value("reset result_valid", result_valid, 0);
    check_value("reset buffer_empty", buffer_empty, 1);
    check_value("reset buffer_full", buffer_full, 0);
    check_value("reset mem_command", mem_command, dcache_pkg::BUS_NONE);
endtask

task automatic miss_then_hit();
    load_miss(16'h0104, dcache_pkg::WORD, 1'b0, 5'd3, 1'b1);
    wait_result(expected_load(16'h0104, dcache_pkg::WORD, 1'b0), 5'd3);
    load_hit(16'h0100, dcache_pkg::WORD, 1'b0, 5'd4);
endtask

task automatic size_and_sign();
    for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 8; off++) begin
            load_hit(16'(16'h0100 + off), dcache_pkg::BYTE, s[0], 5'(off));
        end
        for (int off = 0; off < 8; off += 2) begin
            load_hit(16'(16'h0100 + off), dcache_pkg::HALF, s[0], 5'(off));
        end
        load_hit(16'h0100, dcache_pkg::WORD, s[0], 5'd1);
        load_hit(16'h0104, dcache_pkg::WORD, s[0], 5'd2);
    end
endtask

task automatic store_through();
    store_write(16'h0103, dcache_pkg::BYTE, 32'h0000_008a);
    load_hit(16'h0100, dcache_pkg::WORD, 1'b0, 5'd6);
    store_write(16'h0106, dcache_pkg::HALF, 32'h0000_f00d);
    load_hit(16'h0104, dcache_pkg::WORD, 1'b0, 5'd7);
    load_hit(16'h0106, dcache_pkg::HALF, 1'b1, 5'd8);
    store_write(16'h0100, dcache_pkg::WORD, 32'hdead_beef);
    load_hit(16'h0100, dcache_pkg::WORD, 1'b0, 5'd9);
endtask

// Block of set 5 with the given tag
function automatic dcache_pkg::addr_t set5_block(int tag);
    return 16'(tag * 64 + 40);
endfunction

task automatic plru_replacement();
    for (int t = 0; t < 4; t++) begin
        load_miss(set5_block(16 + t), dcache_pkg::WORD, 1'b0, 5'(t), 1'b1);
        wait_result(expected_load(set5_block(16 + t), dcache_pkg::WORD, 1'b0), 5'(t));
    end
    // Fills leave all tree bits zero; touching way 0 then way 2 makes way 1 the victim
    load_hit(set5_block(16), dcache_pkg::WORD, 1'b0, 5'd4);
    load_hit(set5_block(18), dcache_pkg::WORD, 1'b0, 5'd5);
    load_miss(set5_block(20), dcache_pkg::WORD, 1'b0, 5'd6, 1'b1);
    wait_result(expected_load(set5_block(20), dcache_pkg::WORD, 1'b0), 5'd6);
    load_hit(set5_block(16), dcache_pkg::WORD, 1'b0, 5'd7);
    load_hit(set5_block(18), dcache_pkg::WORD, 1'b0, 5'd8);
    load_hit(set5_block(19), dcache_pkg::WORD, 1'b0, 5'd9);
    load_hit(set5_block(20), dcache_pkg::WORD, 1'b0, 5'd10);
    load_miss(set5_block(17), dcache_pkg::WORD, 1'b0, 5'd11, 1'b1);
    wait_result(expected_load(set5_block(17), dcache_pkg::WORD, 1'b0), 5'd11);
endtask

task automatic outstanding_and_flush();
    hold_responses = 1'b1;
    for (int i = 0; i < BUFFER_DEPTH; i++) begin
        load_miss(16'(16'h2000 + i * 8), dcache_pkg::WORD, 1'b0, 5'(12 + i), 1'b0);
    end
    @(posedge clock);
    check_value("buffer_full", buffer_full, 1);
    hold_responses = 1'b0;
    for (int i = 0; i < BUFFER_DEPTH; i++) begin
        wait_result(expected_load(16'(16'h2000 + i * 8), dcache_pkg::WORD, 1'b0), 5'(12 + i));
    end
    hold_responses = 1'b1;
    load_miss(16'h3000, dcache_pkg::WORD, 1'b0, 5'd20, 1'b0);
    load_miss(16'h3008, dcache_pkg::WORD, 1'b0, 5'd21, 1'b0);
    @(posedge clock);
    check_value("pending buffer_empty", buffer_empty, 0);
    @(negedge clock);
    flush = 1'b1;
    @(negedge clock);
    flush = 1'b0;
    @(posedge clock);
    check_value("flush buffer_empty", buffer_empty, 1);
    hold_responses = 1'b0;
    repeat (20) begin
        @(posedge clock);
        check_value("flushed result_valid", result_valid, 0);
    end
endtask

`endif

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

    localparam int BUFFER_DEPTH = 4;
    localparam int RESET_CYCLES = 10;
    // Doubled cycle budget of all tests
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 40 + 70 + 30 + 220 + 120);

    logic clock;
    logic reset;
    logic load_valid;
    dcache_pkg::addr_t load_addr;
    dcache_pkg::mem_size_e load_size;
    logic load_signed;
    dcache_pkg::id_t load_id;
    logic store_valid;
    dcache_pkg::addr_t store_addr;
    dcache_pkg::mem_size_e store_size;
    logic [31:0] store_data;
    logic mem_response_valid;
    dcache_pkg::mem_tag_t mem_response;
    logic [63:0] mem_data;
    dcache_pkg::mem_tag_t mem_data_tag;
    logic flush;
    logic result_valid;
    logic [31:0] result_value;
    dcache_pkg::id_t result_id;
    logic buffer_full;
    logic buffer_empty;
    dcache_pkg::bus_command_e mem_command;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::mem_size_e mem_size;
    logic [63:0] mem_store_data;

    // Memory model state
    logic [7:0] shadow [65536];
    int cycle;
    int load_wait;
    int last_due;
    logic hold_responses;
    logic resp_next_valid;
    dcache_pkg::mem_tag_t next_tag;
    dcache_pkg::mem_tag_t data_next_tag;
    logic [63:0] data_next;
    dcache_pkg::mem_tag_t ret_tag [$];
    dcache_pkg::addr_t ret_addr [$];
    int ret_due [$];

    dcache #(.BUFFER_DEPTH(BUFFER_DEPTH)) dut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Initial memory contents depend on every address bit
    function automatic logic [7:0] fill_byte(int addr);
        return 8'(addr * 37) ^ 8'(addr >> 8) ^ 8'h9c;
    endfunction

    function automatic logic [63:0] shadow_block(dcache_pkg::addr_t base);
        logic [63:0] blk;
        for (int i = 0; i < 8; i++) begin
            blk[i*8 +: 8] = shadow[16'(base + i)];
        end
        return blk;
    endfunction

    // Little-endian extract with sign or zero extension
    function automatic logic [31:0] expected_load(dcache_pkg::addr_t addr,
                                                  dcache_pkg::mem_size_e size, logic sgn);
        logic [31:0] value;
        value = {shadow[16'(addr + 3)], shadow[16'(addr + 2)],
                 shadow[16'(addr + 1)], shadow[addr]};
        case (size)
            dcache_pkg::BYTE: value = {{24{sgn & value[7]}}, value[7:0]};
            dcache_pkg::HALF: value = {{16{sgn & value[15]}}, value[15:0]};
            default: value = value;
        endcase
        return value;
    endfunction

    task automatic check_value(string what, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // Memory model samples at the rising edge and drives at the falling edge
    initial begin
        void'($urandom(75));
        forever begin
            @(posedge clock);
            cycle++;
            if (cycle > TIMEOUT_CYCLES) begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display(">>> FAIL");
                $fatal(1, "Timeout");
            end
            if (!reset) begin
                if (mem_command == dcache_pkg::BUS_STORE) begin
                    for (int i = 0; i < (1 << mem_size); i++) begin
                        shadow[16'(mem_addr + i)] = mem_store_data[i*8 +: 8];
                    end
                end
                if (mem_command == dcache_pkg::BUS_LOAD && mem_response_valid
                    && mem_response != '0) begin
                    ret_tag.push_back(mem_response);
                    ret_addr.push_back(mem_addr);
                    last_due = (cycle + 2 > last_due) ? cycle + $urandom_range(2, 6)
                                                      : last_due + 1;
                    ret_due.push_back(last_due);
                    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                    resp_next_valid = 1'b0;
                    load_wait = -1;
                end else if (mem_command == dcache_pkg::BUS_LOAD && !hold_responses) begin
                    if (load_wait < 0) begin
                        load_wait = $urandom_range(1, 3);
                    end
                    if (load_wait > 0) begin
                        load_wait--;
                    end
                    resp_next_valid = (load_wait == 0);
                end else begin
                    resp_next_valid = 1'b0;
                    load_wait = -1;
                end
                data_next_tag = '0;
                if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
                    data_next_tag = ret_tag.pop_front();
                    data_next = shadow_block(ret_addr.pop_front());
                    void'(ret_due.pop_front());
                end
            end
        end
    end

    always @(negedge clock) begin
        mem_response_valid <= resp_next_valid;
        mem_response <= next_tag;
        mem_data_tag <= data_next_tag;
        mem_data <= data_next;
    end

    `include "dcache_tests.svh"

    initial begin
        reset = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_size = dcache_pkg::BYTE;
        load_signed = 1'b0;
        load_id = '0;
        store_valid = 1'b0;
        store_addr = '0;
        store_size = dcache_pkg::BYTE;
        store_data = '0;
        mem_response_valid = 1'b0;
        mem_response = '0;
        mem_data = '0;
        mem_data_tag = '0;
        flush = 1'b0;
        cycle = 0;
        load_wait = -1;
        last_due = 0;
        hold_responses = 1'b0;
        resp_next_valid = 1'b0;
        next_tag = 4'd1;
        data_next_tag = '0;
        data_next = '0;
        for (int a = 0; a < 65536; a++) begin
            shadow[a] = fill_byte(a);
        end
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        reset_outputs();
        miss_then_hit();
        size_and_sign();
        store_through();
        plru_replacement();
        outstanding_and_flush();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+testbench
logic/dcache_pkg.sv
logic/lookup_if.sv
logic/tag_lookup.sv
logic/tree_plru.sv
logic/cache_array.sv
logic/miss_buffer.sv
logic/load_align.sv
logic/dcache.sv
testbench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/lookup_if.sv
  - logic/tag_lookup.sv
  - logic/tree_plru.sv
  - logic/cache_array.sv
  - logic/miss_buffer.sv
  - logic/load_align.sv
  - logic/dcache.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/dcache_tb.sv
